/* all.f */
logic/exec_pkg.sv
logic/op_decode.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/reorder_buffer.sv
logic/exec_cluster.sv
verification/exec_cluster_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module exec_cluster_tb -f all.f -o exec_cluster_sim

output=$(./obj_dir/exec_cluster_sim)
echo "$output"

if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1

/* verification/exec_cluster_tb.sv */
// Testbench for the integer execution cluster with reference model and in-order checks
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_tb;
    import exec_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int ALU_PER_OP = 6;
    localparam int MUL_RAND   = 6;
    localparam int DIV_RAND   = 5;
    localparam int MIX_OPS    = 60;
    localparam int BP_OPS     = 40;
    localparam int TOTAL_OPS  = 10 * ALU_PER_OP + 4 * (MUL_RAND + 8) + 4 * (DIV_RAND + 3)
                                + MIX_OPS + BP_OPS;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * 40 + 500;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    issue_req_t in_data;
    logic       in_ready;
    logic       out_valid;
    retire_t    out_data;
    logic       out_ready;
    logic       stall_en;

    int      seed = 32'h29be_3c56;
    retire_t exp_q [$];
    int      outstanding = 0;
    int      full_seen = 0;
    int      errors = 0;
    int      checks = 0;
    int      tests_run = 0;
    int      tests_ok = 0;

    exec_cluster i_exec_cluster (
         .clk_i(clk)
        ,.rst_n_i(rst_n)
        ,.in_valid_i(in_valid)
        ,.in_data_i(in_data)
        ,.in_ready_o(in_ready)
        ,.out_valid_o(out_valid)
        ,.out_data_o(out_data)
        ,.out_ready_i(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //------------------------------------------------------------
    // Reference model and stimulus helpers
    //------------------------------------------------------------
    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic retire_t ref_exec(input issue_req_t req);
        logic [6:0]  opc;
        logic [6:0]  f7;
        funct3_t     f3;
        xlen_t       a;
        xlen_t       b;
        logic [63:0] wide;
        logic        overflow;
        retire_t     r;
        opc = req.instr[6:0];
        f7 = req.instr[31:25];
        f3 = req.instr[14:12];
        a = req.op_a;
        b = req.op_b;
        r.rd = req.instr[11:7];
        r.value = '0;
        r.illegal = 1'b0;
        overflow = a == 32'h8000_0000 && b == 32'hffff_ffff;
        if (opc != OPCODE_OP) begin
            r.illegal = 1'b1;
        end else if (f7 == FUNCT7_MULDIV) begin
            case (f3)
                3'd0: begin
                    wide = {32'b0, a} * {32'b0, b};
                    r.value = wide[31:0];
                end
                3'd1: begin
                    wide = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                    r.value = wide[63:32];
                end
                3'd2: begin
                    wide = $signed({{32{a[31]}}, a}) * $signed({32'b0, b});
                    r.value = wide[63:32];
                end
                3'd3: begin
                    wide = {32'b0, a} * {32'b0, b};
                    r.value = wide[63:32];
                end
                3'd4: begin
                    if (b == 0) begin
                        r.value = 32'hffff_ffff;
                    end else if (overflow) begin
                        r.value = a;
                    end else begin
                        r.value = $signed(a) / $signed(b);
                    end
                end
                3'd5: r.value = (b == 0) ? 32'hffff_ffff : a / b;
                3'd6: begin
                    if (b == 0) begin
                        r.value = a;
                    end else if (overflow) begin
                        r.value = '0;
                    end else begin
                        r.value = $signed(a) % $signed(b);
                    end
                end
                default: r.value = (b == 0) ? a : a % b;
            endcase
        end else if (f7 == FUNCT7_BASE || (f7 == FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5))) begin
            case (f3)
                3'd0: r.value = (f7 == FUNCT7_ALT) ? a - b : a + b;
                3'd1: r.value = a << b[4:0];
                // Signed compare by flipping the sign bits
                3'd2: r.value = xlen_t'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
                3'd3: r.value = xlen_t'(a < b);
                3'd4: r.value = a ^ b;
                3'd5: begin
                    wide = {{32{a[31] & f7[5]}}, a} >> b[4:0];
                    r.value = wide[31:0];
                end
                3'd6: r.value = a | b;
                default: r.value = a & b;
            endcase
        end else begin
            r.illegal = 1'b1;
        end
        return r;
    endfunction

    function automatic instr_t make_instr(input logic [6:0] f7, input funct3_t f3);
        return {f7, 5'd7, 5'd6, f3, reg_idx_t'(next_random()), OPCODE_OP};
    endfunction

    // Ten base ops with SUB and SRA last
    function automatic instr_t alu_instr(input int k);
        if (k < 8) begin
            return make_instr(FUNCT7_BASE, funct3_t'(k));
        end
        return make_instr(FUNCT7_ALT, (k == 8) ? 3'd0 : 3'd5);
    endfunction

    task automatic check_retire(input retire_t got, input retire_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: got rd %0d value %h ill %b, exp rd %0d value %h ill %b",
                     $time, got.rd, got.value, got.illegal, exp.rd, exp.value, exp.illegal);
        end
    endtask

    task automatic send(input issue_req_t req);
        @(negedge clk);
        in_valid = 1'b1;
        in_data = req;
        do begin
            @(posedge clk);
        end while (!in_ready);
    endtask

    task automatic drain();
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0 || outstanding != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            tests_ok++;
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic random_mix(output issue_req_t req);
        int kind;
        kind = int'(next_random() % 8);
        req.op_a = next_random();
        req.op_b = next_random();
        if (kind < 4) begin
            req.instr = alu_instr(int'(next_random() % 10));
        end else if (kind < 6) begin
            req.instr = make_instr(FUNCT7_MULDIV, funct3_t'(next_random() % 4));
        end else if (kind == 6) begin
            req.instr = make_instr(FUNCT7_MULDIV, funct3_t'(4 + next_random() % 4));
            req.op_b = req.op_b >> (next_random() % 32);
        end else begin
            // Illegal word from a foreign opcode or a bad funct7
            req.instr = next_random();
            if (next_random() % 2 == 0) begin
                req.instr[31:25] = FUNCT7_ALT;
                req.instr[14:12] = 3'b001;
                req.instr[6:0] = OPCODE_OP;
            end else if (req.instr[6:0] == OPCODE_OP) begin
                req.instr[0] = 1'b0;
            end
        end
    endtask

    //------------------------------------------------------------
    // Tests
    //------------------------------------------------------------
    task automatic alu_test();
        issue_req_t req;
        for (int k = 0; k < 10; k++) begin
            for (int i = 0; i < ALU_PER_OP; i++) begin
                req.instr = alu_instr(k);
                req.op_a = next_random();
                req.op_b = next_random();
                if (i < 2) begin
                    req.op_a[31] = 1'b1;
                end
                if (i == 1) begin
                    req.op_b[31] = 1'b1;
                end
                send(req);
            end
        end
        drain();
    endtask

    task automatic mul_test();
        issue_req_t req;
        xlen_t      extremes [4];
        extremes = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h0000_0001};
        for (int f = 0; f < 4; f++) begin
            req.instr = make_instr(FUNCT7_MULDIV, funct3_t'(f));
            for (int i = 0; i < MUL_RAND; i++) begin
                req.op_a = next_random();
                req.op_b = next_random();
                send(req);
            end
            for (int j = 0; j < 4; j++) begin
                req.op_a = extremes[j];
                req.op_b = extremes[j];
                send(req);
                req.op_b = extremes[3-j];
                send(req);
            end
        end
        drain();
    endtask

    task automatic div_test();
        issue_req_t req;
        for (int f = 4; f < 8; f++) begin
            req.instr = make_instr(FUNCT7_MULDIV, funct3_t'(f));
            for (int i = 0; i < DIV_RAND; i++) begin
                req.op_a = next_random();
                req.op_b = next_random() >> (next_random() % 32);
                send(req);
            end
            req.op_b = '0;
            send(req);
            req.op_a = 32'h8000_0000;
            req.op_b = 32'hffff_ffff;
            send(req);
            req.op_a = next_random() | 32'h8000_0000;
            req.op_b = 32'd7;
            send(req);
        end
        drain();
    endtask

    task automatic mix_test(input int count);
        issue_req_t req;
        for (int i = 0; i < count; i++) begin
            random_mix(req);
            send(req);
        end
        drain();
    endtask

    // Output handshake monitor and compare
    always @(posedge clk) begin
        if (rst_n) begin
            if (outstanding == ROB_DEPTH) begin
                full_seen++;
                if (in_ready) begin
                    errors++;
                    $display("At %0t the input was ready with %0d instructions outstanding",
                             $time, outstanding);
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(ref_exec(in_data));
                outstanding++;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("At %0t a result came out with nothing outstanding", $time);
                end else begin
                    check_retire(out_data, exp_q.pop_front());
                end
                outstanding--;
            end
        end
    end

    // Random output stalls
    initial begin
        int hold;
        hold = 0;
        forever begin
            @(negedge clk);
            if (!stall_en) begin
                out_ready = 1'b1;
                hold = 0;
            end else if (hold == 0) begin
                out_ready = !out_ready;
                hold = out_ready ? 1 + int'(next_random() % 3) : 8 + int'(next_random() % 23);
            end else begin
                hold--;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int start;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b1;
        stall_en = 1'b0;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start = errors;
        alu_test();
        report_test("ALU operations", start);
        start = errors;
        mul_test();
        report_test("multiply forms", start);
        start = errors;
        div_test();
        report_test("divide forms", start);
        start = errors;
        mix_test(MIX_OPS);
        report_test("random mix", start);

        start = errors;
        stall_en = 1'b1;
        full_seen = 0;
        mix_test(BP_OPS);
        stall_en = 1'b0;
        if (full_seen == 0) begin
            errors++;
            $display("The buffer never held %0d instructions under back-pressure", ROB_DEPTH);
        end
        report_test("output back-pressure", start);

        $display("Tests passed %0d of %0d, checks %0d, errors %0d",
                 tests_ok, tests_run, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/exec_cluster.sv */
// Integer execution cluster joining decoder, ALU, multiplier, divider and reorder buffer
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
     input  logic                  clk_i
    ,input  logic                  rst_n_i
    ,input  logic                  in_valid_i
    ,input  exec_pkg::issue_req_t  in_data_i
    ,output logic                  in_ready_o
    ,output logic                  out_valid_o
    ,output exec_pkg::retire_t     out_data_o
    ,input  logic                  out_ready_i
);
    import exec_pkg::*;

    exec_op_t     op_w;
    logic         alu_issue_w;
    logic         mul_issue_w;
    logic         div_issue_w;
    logic         alloc_valid_w;
    rob_alloc_t   alloc_w;
    logic         rob_full_w;
    logic         div_busy_w;
    logic         alu_done_w;
    unit_result_t alu_result_w;
    logic         mul_done_w;
    unit_result_t mul_result_w;
    logic         div_done_w;
    unit_result_t div_result_w;

    op_decode u_decode (
         .clk_i(clk_i)
        ,.rst_n_i(rst_n_i)
        ,.in_valid_i(in_valid_i)
        ,.in_data_i(in_data_i)
        ,.in_ready_o(in_ready_o)
        ,.rob_full_i(rob_full_w)
        ,.div_busy_i(div_busy_w)
        ,.op_o(op_w)
        ,.alu_issue_o(alu_issue_w)
        ,.mul_issue_o(mul_issue_w)
        ,.div_issue_o(div_issue_w)
        ,.alloc_valid_o(alloc_valid_w)
        ,.alloc_o(alloc_w)
    );

    alu_unit u_alu (
         .clk_i(clk_i)
        ,.rst_n_i(rst_n_i)
        ,.issue_i(alu_issue_w)
        ,.op_i(op_w)
        ,.done_o(alu_done_w)
        ,.result_o(alu_result_w)
    );

    mul_unit u_mul (
         .clk_i(clk_i)
        ,.rst_n_i(rst_n_i)
        ,.issue_i(mul_issue_w)
        ,.op_i(op_w)
        ,.done_o(mul_done_w)
        ,.result_o(mul_result_w)
    );

    div_unit u_div (
         .clk_i(clk_i)
        ,.rst_n_i(rst_n_i)
        ,.issue_i(div_issue_w)
        ,.op_i(op_w)
        ,.busy_o(div_busy_w)
        ,.done_o(div_done_w)
        ,.result_o(div_result_w)
    );

    reorder_buffer u_rob (
         .clk_i(clk_i)
        ,.rst_n_i(rst_n_i)
        ,.alloc_valid_i(alloc_valid_w)
        ,.alloc_i(alloc_w)
        ,.alu_done_i(alu_done_w)
        ,.alu_result_i(alu_result_w)
        ,.mul_done_i(mul_done_w)
        ,.mul_result_i(mul_result_w)
        ,.div_done_i(div_done_w)
        ,.div_result_i(div_result_w)
        ,.rob_full_o(rob_full_w)
        ,.out_valid_o(out_valid_o)
        ,.out_data_o(out_data_o)
        ,.out_ready_i(out_ready_i)
    );

endmodule

`default_nettype wire

/* logic/reorder_buffer.sv */
// Reorder buffer that collects unit results and retires them in program order
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
     input  logic                    clk_i
    ,input  logic                    rst_n_i
    ,input  logic                    alloc_valid_i
    ,input  exec_pkg::rob_alloc_t    alloc_i
    ,input  logic                    alu_done_i
    ,input  exec_pkg::unit_result_t  alu_result_i
    ,input  logic                    mul_done_i
    ,input  exec_pkg::unit_result_t  mul_result_i
    ,input  logic                    div_done_i
    ,input  exec_pkg::unit_result_t  div_result_i
    ,output logic                    rob_full_o
    ,output logic                    out_valid_o
    ,output exec_pkg::retire_t       out_data_o
    ,input  logic                    out_ready_i
);
    import exec_pkg::*;

    reg_idx_t             rd_q [ROB_DEPTH];
    xlen_t                value_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] illegal_q;
    logic [ROB_DEPTH-1:0] done_q;
    rob_tag_t             head_q;
    logic [ROB_TAG_W:0]   count_q;
    logic                 ill_done_q;
    rob_tag_t             ill_tag_q;
    logic                 retire;
    rob_tag_t             sel;
    logic                 load;

    function automatic logic in_use(rob_tag_t tag);
        return {1'b0, rob_tag_t'(tag - head_q)} < count_q;
    endfunction

    // Top count bit set means all slots taken
    assign rob_full_o = count_q[ROB_TAG_W];
    assign retire     = out_valid_o && out_ready_i;
    assign sel        = retire ? rob_tag_t'(head_q + 1'b1) : head_q;
    assign load       = done_q[sel] && (retire || !out_valid_o);

    //----------------------------------------------------------
    // Slot and pointer control
    //----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q      <= '0;
            count_q     <= '0;
            done_q      <= '0;
            ill_done_q  <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            // Illegal words complete a cycle after allocation
            ill_done_q <= alloc_valid_i && alloc_i.illegal;
            if (alloc_valid_i) begin
                done_q[alloc_i.tag] <= 1'b0;
            end
            if (ill_done_q) begin
                done_q[ill_tag_q] <= 1'b1;
            end
            if (alu_done_i) begin
                done_q[alu_result_i.tag] <= 1'b1;
            end
            if (mul_done_i) begin
                done_q[mul_result_i.tag] <= 1'b1;
            end
            if (div_done_i) begin
                done_q[div_result_i.tag] <= 1'b1;
            end
            if (retire) begin
                done_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            case ({alloc_valid_i, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            if (load) begin
                out_valid_o <= 1'b1;
            end else if (retire) begin
                out_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        ill_tag_q <= alloc_i.tag;
        if (alloc_valid_i) begin
            rd_q[alloc_i.tag]      <= alloc_i.rd;
            illegal_q[alloc_i.tag] <= alloc_i.illegal;
            value_q[alloc_i.tag]   <= '0;
        end
        if (alu_done_i) begin
            value_q[alu_result_i.tag] <= alu_result_i.value;
        end
        if (mul_done_i) begin
            value_q[mul_result_i.tag] <= mul_result_i.value;
        end
        if (div_done_i) begin
            value_q[div_result_i.tag] <= div_result_i.value;
        end
        // Head result registered as the output
        if (load) begin
            out_data_o.rd      <= rd_q[sel];
            out_data_o.value   <= value_q[sel];
            out_data_o.illegal <= illegal_q[sel];
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!alu_done_i || in_use(alu_result_i.tag)) &&
        (!mul_done_i || in_use(mul_result_i.tag)) &&
        (!div_done_i || in_use(div_result_i.tag)));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alloc_valid_i |-> !rob_full_o);

endmodule

`default_nettype wire

/* logic/div_unit.sv */
// Iterative restoring divider for DIV, DIVU, REM and REMU
`timescale 1ns/1ps
`default_nettype none

module div_unit (
     input  logic                    clk_i
    ,input  logic                    rst_n_i
    ,input  logic                    issue_i
    ,input  exec_pkg::exec_op_t      op_i
    ,output logic                    busy_o
    ,output logic                    done_o
    ,output exec_pkg::unit_result_t  result_o
);
    import exec_pkg::*;

    div_state_e           state_q;
    logic [DIV_CNT_W-1:0] count_q;
    xlen_t                quo_q;
    xlen_t                rem_q;
    xlen_t                divisor_q;
    rob_tag_t             tag_q;
    logic                 rem_sel_q;
    logic                 neg_quo_q;
    logic                 neg_rem_q;
    logic                 is_signed;
    xlen_t                abs_a;
    xlen_t                abs_b;
    logic [XLEN:0]        rem_shift;
    logic                 fits;

    assign is_signed = !op_i.funct3[0];
    assign abs_a     = (is_signed && op_i.op_a[XLEN-1]) ? -op_i.op_a : op_i.op_a;
    assign abs_b     = (is_signed && op_i.op_b[XLEN-1]) ? -op_i.op_b : op_i.op_b;
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign fits      = rem_shift >= {1'b0, divisor_q};
    assign busy_o    = state_q != DIV_IDLE;

    //----------------------------------------------------------
    // Sequencing
    //----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= DIV_IDLE;
            count_q <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                DIV_IDLE: begin
                    count_q <= '0;
                    if (issue_i) begin
                        state_q <= DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    count_q <= count_q + 1'b1;
                    if (count_q == DIV_CNT_W'(DIV_CYCLES - 1)) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: begin
                    state_q <= DIV_IDLE;
                    done_o  <= 1'b1;
                end
            endcase
        end
    end

    //----------------------------------------------------------
    // Datapath
    //----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (state_q == DIV_IDLE && issue_i) begin
            quo_q     <= abs_a;
            rem_q     <= '0;
            divisor_q <= abs_b;
            tag_q     <= op_i.tag;
            rem_sel_q <= op_i.funct3[1];
            // Zero divisor keeps the all-ones quotient unsigned
            neg_quo_q <= is_signed && (op_i.op_a[XLEN-1] ^ op_i.op_b[XLEN-1]) && |op_i.op_b;
            neg_rem_q <= is_signed && op_i.op_a[XLEN-1];
        end else if (state_q == DIV_RUN) begin
            quo_q <= {quo_q[XLEN-2:0], fits};
            if (fits) begin
                rem_q <= xlen_t'(rem_shift - {1'b0, divisor_q});
            end else begin
                rem_q <= rem_shift[XLEN-1:0];
            end
        end
        // Most negative by -1 negates back to the dividend with remainder 0
        if (state_q == DIV_DONE) begin
            result_o.tag <= tag_q;
            if (rem_sel_q) begin
                result_o.value <= neg_rem_q ? -rem_q : rem_q;
            end else begin
                result_o.value <= neg_quo_q ? -quo_q : quo_q;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) done_o |=> !done_o);

endmodule

`default_nettype wire

/* logic/mul_unit.sv */
// Two-stage pipelined multiplier for MUL, MULH, MULHSU and MULHU
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
     input  logic                    clk_i
    ,input  logic                    rst_n_i
    ,input  logic                    issue_i
    ,input  exec_pkg::exec_op_t      op_i
    ,output logic                    done_o
    ,output exec_pkg::unit_result_t  result_o
);
    import exec_pkg::*;

    logic [MUL_LATENCY-1:0]   valid_q;
    logic signed [XLEN:0]     a_q;
    logic signed [XLEN:0]     b_q;
    logic                     high_q;
    rob_tag_t                 tag_q;
    logic                     a_signed;
    logic                     b_signed;
    logic signed [2*XLEN+1:0] product;

    // MULH signs both operands, MULHSU only the first
    assign a_signed = op_i.funct3[1:0] == 2'b01 || op_i.funct3[1:0] == 2'b10;
    assign b_signed = op_i.funct3[1:0] == 2'b01;
    assign product  = a_q * b_q;
    assign done_o   = valid_q[MUL_LATENCY-1];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[MUL_LATENCY-2:0], issue_i};
        end
    end

    //----------------------------------------------------------
    // Stage one extends, stage two multiplies
    //----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            a_q    <= {a_signed && op_i.op_a[XLEN-1], op_i.op_a};
            b_q    <= {b_signed && op_i.op_b[XLEN-1], op_i.op_b};
            high_q <= |op_i.funct3[1:0];
            tag_q  <= op_i.tag;
        end
        if (valid_q[0]) begin
            result_o.tag   <= tag_q;
            result_o.value <= high_q ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];
        end
    end

endmodule

`default_nettype wire

/* logic/alu_unit.sv */
// Single-cycle integer ALU for the base OP instructions with registered result
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
     input  logic                    clk_i
    ,input  logic                    rst_n_i
    ,input  logic                    issue_i
    ,input  exec_pkg::exec_op_t      op_i
    ,output logic                    done_o
    ,output exec_pkg::unit_result_t  result_o
);
    import exec_pkg::*;

    xlen_t      a;
    xlen_t      b;
    logic [4:0] shamt;
    xlen_t      value;

    assign a     = op_i.op_a;
    assign b     = op_i.op_b;
    assign shamt = op_i.op_b[4:0];

    always_comb begin
        case (op_i.funct3)
            3'b000:  value = op_i.alt ? a - b : a + b;
            3'b001:  value = a << shamt;
            3'b010:  value = xlen_t'($signed(a) < $signed(b));
            3'b011:  value = xlen_t'(a < b);
            3'b100:  value = a ^ b;
            // SRA when the alternate bit is set
            3'b101:  value = op_i.alt ? xlen_t'($signed(a) >>> shamt) : a >> shamt;
            3'b110:  value = a | b;
            default: value = a & b;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            done_o <= 1'b0;
        end else begin
            done_o <= issue_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            result_o.tag   <= op_i.tag;
            result_o.value <= value;
        end
    end

endmodule

`default_nettype wire

/* logic/op_decode.sv */
// Instruction decoder with reorder tag allocation and dispatch to the execution units
`timescale 1ns/1ps
`default_nettype none

module op_decode (
     input  logic                  clk_i
    ,input  logic                  rst_n_i
    ,input  logic                  in_valid_i
    ,input  exec_pkg::issue_req_t  in_data_i
    ,output logic                  in_ready_o
    ,input  logic                  rob_full_i
    ,input  logic                  div_busy_i
    ,output exec_pkg::exec_op_t    op_o
    ,output logic                  alu_issue_o
    ,output logic                  mul_issue_o
    ,output logic                  div_issue_o
    ,output logic                  alloc_valid_o
    ,output exec_pkg::rob_alloc_t  alloc_o
);
    import exec_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    funct3_t    funct3;
    logic       is_op;
    logic       is_alu;
    logic       is_mul;
    logic       is_div;
    logic       accept;
    rob_tag_t   tail_q;

    assign opcode = in_data_i.instr[6:0];
    assign funct7 = in_data_i.instr[31:25];
    assign funct3 = in_data_i.instr[14:12];
    assign is_op  = opcode == OPCODE_OP;

    // Alternate encoding only for SUB and SRA
    assign is_alu = is_op && (funct7 == FUNCT7_BASE ||
                    (funct7 == FUNCT7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)));
    assign is_mul = is_op && funct7 == FUNCT7_MULDIV && !funct3[2];
    assign is_div = is_op && funct7 == FUNCT7_MULDIV && funct3[2];

    // Divider holds a single operation
    assign in_ready_o    = !rob_full_i && !(is_div && div_busy_i);
    assign accept        = in_valid_i && in_ready_o;
    assign alloc_valid_o = accept;
    assign alu_issue_o   = accept && is_alu;
    assign mul_issue_o   = accept && is_mul;
    assign div_issue_o   = accept && is_div;

    assign op_o.tag    = tail_q;
    assign op_o.funct3 = funct3;
    assign op_o.alt    = in_data_i.instr[30];
    assign op_o.op_a   = in_data_i.op_a;
    assign op_o.op_b   = in_data_i.op_b;

    // Illegal words get a slot but no unit
    assign alloc_o.tag     = tail_q;
    assign alloc_o.rd      = in_data_i.instr[11:7];
    assign alloc_o.illegal = !(is_alu || is_mul || is_div);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tail_q <= '0;
        end else if (accept) begin
            tail_q <= tail_q + 1'b1;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({alu_issue_o, mul_issue_o, div_issue_o}));

endmodule

`default_nettype wire

/* logic/exec_pkg.sv */
// Execution cluster definitions with widths, RISC-V encodings and payload types
`default_nettype none

package exec_pkg;

    //----------------------------------------------------------
    // Widths and encodings
    //----------------------------------------------------------
    localparam int XLEN        = 32;
    localparam int ROB_DEPTH   = 4;
    localparam int ROB_TAG_W   = $clog2(ROB_DEPTH);
    localparam int MUL_LATENCY = 2;
    localparam int DIV_CYCLES  = 32;
    localparam int DIV_CNT_W   = $clog2(DIV_CYCLES);

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    //----------------------------------------------------------
    // Types
    //----------------------------------------------------------
    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [31:0]          instr_t;
    typedef logic [4:0]           reg_idx_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [2:0]           funct3_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    // Offered on the input handshake
    typedef struct packed {
        instr_t instr;
        xlen_t  op_a;
        xlen_t  op_b;
    } issue_req_t;

    // Dispatched to one unit
    typedef struct packed {
        rob_tag_t tag;
        funct3_t  funct3;
        logic     alt;
        xlen_t    op_a;
        xlen_t    op_b;
    } exec_op_t;

    typedef struct packed {
        rob_tag_t tag;
        xlen_t    value;
    } unit_result_t;

    typedef struct packed {
        rob_tag_t tag;
        reg_idx_t rd;
        logic     illegal;
    } rob_alloc_t;

    typedef struct packed {
        reg_idx_t rd;
        xlen_t    value;
        logic     illegal;
    } retire_t;

endpackage

`default_nettype wire
